// ==== verilog.f ====
common/portalPkg.sv
portalBridge/readChannel.sv
portalBridge/writeChannel.sv
portalBridge/portalCtrlRegs.sv
design/echoUser.sv
design/portalTop.sv
bench/tbClock.sv
bench/portalTop_assertions.sv
bench/portalTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the portal testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f verilog.f --top-module portalTb -o portalSim &&
./obj_dir/portalSim +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== bench/portalTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalTb;

  localparam int queueDepth = 4;
  localparam int cycleLimit = 2000;  // Well above the length of all tests
  localparam portalPkg::portalAddr reqDataAddr = 13'h0020;
  localparam portalPkg::portalAddr indDataAddr = 13'h1020;

  logic                 CLK;
  logic                 RST_N;
  logic                 arValid;
  portalPkg::portalAddr arAddr;
  portalPkg::txnId      arId;
  logic                 arReady;
  logic                 rValid;
  portalPkg::busData    rData;
  portalPkg::txnId      rId;
  logic                 rReady;
  logic                 awValid;
  portalPkg::portalAddr awAddr;
  portalPkg::txnId      awId;
  logic                 awReady;
  logic                 wValid;
  portalPkg::busData    wData;
  logic                 wReady;
  logic                 bValid;
  portalPkg::txnId      bId;
  logic                 bReady;
  logic                 irq;

  portalPkg::busData expected[$];  // Echo scoreboard
  logic [31:0]       lcgState = 32'd62296;
  int                cycles = 0;
  int                tbErrors = 0;
  int                tests = 0;
  int                errorsBefore = 0;

  tbClock clockGen (.CLK(CLK), .RST_N(RST_N));

  portalTop #(.queueDepth(queueDepth)) u_dut (.*);

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == cycleLimit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic waitCycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  task automatic readWord(input portalPkg::portalAddr addr, input int hold,
                          output portalPkg::busData data);
    logic [31:0] rnd;
    rnd = lcgNext();
    arValid = 1'b1;
    arAddr  = addr;
    arId    = rnd[5:0];
    @(negedge CLK);
    while (!arReady)
      @(negedge CLK);
    waitCycles(1);
    arValid = 1'b0;
    if (hold > 0)
      waitCycles(hold);  // rReady kept low
    rReady = 1'b1;
    @(negedge CLK);
    while (!rValid)
      @(negedge CLK);
    data = rData;
    waitCycles(1);
    rReady = 1'b0;
  endtask

  task automatic writeWord(input portalPkg::portalAddr addr, input portalPkg::busData data,
                           input bit dataFirst);
    logic [31:0] rnd;
    logic        awHit;
    logic        wHit;
    logic        awDone;
    rnd     = lcgNext();
    awDone  = 1'b0;
    wValid  = 1'b1;
    wData   = data;
    awAddr  = addr;
    awId    = rnd[5:0];
    awValid = !dataFirst;
    while (!awDone || wValid) begin
      @(negedge CLK);
      awHit = awValid && awReady;
      wHit  = wValid && wReady;
      waitCycles(1);
      if (awHit) begin
        awValid = 1'b0;
        awDone  = 1'b1;
      end
      if (wHit) begin
        wValid  = 1'b0;
        awValid = !awDone;  // Address follows the data beat
      end
    end
  endtask

  task automatic takeWriteResp(input int hold);
    if (hold > 0)
      waitCycles(hold);
    bReady = 1'b1;
    @(negedge CLK);
    while (!bValid)
      @(negedge CLK);
    waitCycles(1);
    bReady = 1'b0;
  endtask

  task automatic pushWord(input portalPkg::busData data, input bit dataFirst);
    writeWord(reqDataAddr, data, dataFirst);
    expected.push_back(data);
    takeWriteResp(0);
  endtask

  task automatic popCheck();
    portalPkg::busData got;
    portalPkg::busData want;
    readWord(indDataAddr, 0, got);
    want = expected.pop_front();
    if (got !== want) begin
      $display("mismatch rData: got %h, expected %h", got, want);
      tbErrors++;
    end
  endtask

  task automatic endTest(input string name);
    int now;
    now = tbErrors + u_dut.checks.failCount;
    tests++;
    $display("test %s: %0d errors", name, now - errorsBefore);
    errorsBefore = now;
  endtask

  initial begin
    portalPkg::busData word;
    portalPkg::busData extra;
    int                total;
    arValid = 1'b0;
    arAddr  = '0;
    arId    = '0;
    rReady  = 1'b0;
    awValid = 1'b0;
    awAddr  = '0;
    awId    = '0;
    wValid  = 1'b0;
    wData   = '0;
    bReady  = 1'b0;
    @(posedge RST_N);
    waitCycles(2);
    endTest("reset");

    for (int p = 0; p < 2; p++)
      for (int off = 0; off <= 'h18; off += 4)
        readWord({p[0], 7'd0, off[4:0]}, 0, word);
    endTest("control page");

    pushWord(lcgNext(), 1'b0);
    pushWord(lcgNext(), 1'b1);
    pushWord(lcgNext(), 1'b0);
    repeat (3) popCheck();
    endTest("echo");

    readWord(13'h1024, 0, word);
    readWord(13'h1000, 0, word);
    writeWord(13'h0004, 32'd1, 1'b0);
    takeWriteResp(0);
    readWord(13'h0004, 0, word);
    pushWord(lcgNext(), 1'b0);
    readWord(13'h1024, 0, word);
    readWord(13'h1000, 0, word);
    readWord(13'h100C, 0, word);
    popCheck();
    readWord(13'h1024, 0, word);
    readWord(13'h1000, 0, word);
    writeWord(13'h1004, 32'd0, 1'b0);  // Enable cleared through the indication portal
    takeWriteResp(0);
    readWord(13'h1004, 0, word);
    endTest("flags and interrupt");

    readWord(13'h1010, 4, word);
    writeWord(13'h0004, 32'd1, 1'b0);
    takeWriteResp(4);
    repeat (queueDepth) pushWord(lcgNext(), 1'b0);
    readWord(13'h0024, 0, word);
    extra = lcgNext();
    writeWord(reqDataAddr, extra, 1'b0);  // No room, response withheld
    expected.push_back(extra);
    waitCycles(4);
    readWord(13'h0024, 0, word);
    popCheck();
    takeWriteResp(0);
    repeat (queueDepth) popCheck();
    extra = lcgNext();
    expected.push_back(extra);
    fork
      popCheck();  // Stalls on the empty queue
      begin
        waitCycles(6);
        writeWord(reqDataAddr, extra, 1'b0);
        takeWriteResp(0);
      end
    join
    endTest("back-pressure");

    total = tbErrors + u_dut.checks.failCount;
    $display("%0d tests run, %0d errors", tests, total);
    if (total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/portalTop_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalTopAssertions #(
  parameter int queueDepth = 4
) (
  input logic                 CLK, RST_N,
  input logic                 arValid, arReady, rValid, rReady,
  input logic                 awValid, awReady, wValid, wReady, bValid, bReady,
  input logic                 irq, indNotEmpty,
  input portalPkg::portalAddr arAddr, awAddr,
  input portalPkg::txnId      arId, rId, awId, bId,
  input portalPkg::busData    rData, wData
);

  int                   failCount = 0;
  portalPkg::portalAddr rdAddr;
  portalPkg::portalAddr wrAddr;
  portalPkg::txnId      rdId;
  portalPkg::txnId      wrId;
  portalPkg::busData    wrWord;
  logic                 enModel;   // Expected interrupt enable
  logic                 rValidD;
  logic                 bValidD;
  logic                 pushDone;
  logic                 popDone;
  int                   occ;       // Queue words as seen from the host, one edge late
  logic                 rdCtrl;
  logic                 popRead;
  logic                 pushWrite;

  assign rdCtrl    = (rdAddr[11:5] == 7'd0);
  assign popRead   = !rdCtrl && rdAddr[12] && (rdAddr[4:0] == 5'h00);
  assign pushWrite = (wrAddr[11:5] != 7'd0) && !wrAddr[12] && (wrAddr[4:0] == 5'h00);

  // A response rising marks the push or pop one edge earlier
  assign pushDone = bValid && !bValidD && pushWrite;
  assign popDone  = rValid && !rValidD && popRead;

  always_ff @(posedge CLK) begin
    rValidD <= rValid;
    bValidD <= bValid;
    if (!RST_N)
      occ <= 0;
    else
      occ <= occ + int'(pushDone) - int'(popDone);
    if (arValid && arReady) begin
      rdAddr <= arAddr;
      rdId   <= arId;
    end
    if (awValid && awReady) begin
      wrAddr <= awAddr;
      wrId   <= awId;
    end
    if (wValid && wReady)
      wrWord <= wData;
    if (!RST_N)
      enModel <= 1'b0;
    else if (bValid && bReady && wrAddr[11:0] == 12'h004)  // Enable word of either portal
      enModel <= wrWord[0];
  end

  function automatic portalPkg::busData controlWord(input logic [4:0] off, input logic ind,
                                                    input logic notEmpty, input logic en);
    case (off)
      5'h00:   return {31'd0, ind && notEmpty};
      5'h04:   return {31'd0, en};
      5'h08:   return 32'd1;
      5'h0C:   return {31'd0, notEmpty};
      5'h10:   return ind ? 32'd6 : 32'd5;
      5'h14:   return 32'd2;
      default: return 32'h005A05A0;
    endcase
  endfunction

  task automatic recordFailure(input string what);
    failCount++;
    $error("%s", what);
  endtask

  assert property (@(posedge CLK) $rose(RST_N) |->
      !rValid && !bValid && !irq && arReady && awReady && wReady)
    else recordFailure("handshake outputs wrong after reset");
  assert property (@(posedge CLK) disable iff (!RST_N) rValid |-> rId == rdId)
    else recordFailure("rId differs from the accepted arId");
  assert property (@(posedge CLK) disable iff (!RST_N) bValid |-> bId == wrId)
    else recordFailure("bId differs from the accepted awId");
  assert property (@(posedge CLK) disable iff (!RST_N)
      rValid && !rReady |=> rValid && $stable(rData) && $stable(rId))
    else recordFailure("read response changed under back-pressure");
  assert property (@(posedge CLK) disable iff (!RST_N)
      bValid && !bReady |=> bValid && $stable(bId))
    else recordFailure("write response changed under back-pressure");
  assert property (@(posedge CLK) disable iff (!RST_N) $rose(rValid) && rdCtrl |->
      rData == controlWord(rdAddr[4:0], rdAddr[12], occ != 0, enModel))
    else recordFailure("control page word wrong");
  assert property (@(posedge CLK) disable iff (!RST_N)
      $rose(rValid) && !rdCtrl && rdAddr[4:0] == 5'h04 |->
      rData == {31'd0, rdAddr[12] ? (occ != 0) : (occ != queueDepth)})
    else recordFailure("queue flag read wrong");
  // Pop and push only complete when the queue allows it
  assert property (@(posedge CLK) disable iff (!RST_N) $rose(rValid) && popRead |-> occ != 0)
    else recordFailure("indication read answered on an empty queue");
  assert property (@(posedge CLK) disable iff (!RST_N)
      $rose(bValid) && pushWrite |-> occ != queueDepth)
    else recordFailure("request write answered while the queue was full");
  assert property (@(posedge CLK) disable iff (!RST_N)
      !bValid |-> irq == (enModel && indNotEmpty))
    else recordFailure("irq does not follow enable and pending indication");

endmodule

bind portalTop portalTopAssertions #(.queueDepth(queueDepth)) checks (.*);

`default_nettype wire

// ==== bench/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic CLK,
  output logic RST_N
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period
  end

  // Reset held low for two rising edges
  initial begin
    RST_N = 1'b0;
    repeat (2) @(posedge CLK);
    #1 RST_N = 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/portalTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalTop #(
  parameter int queueDepth = 4
) (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic                 arValid,
  input  portalPkg::portalAddr arAddr,
  input  portalPkg::txnId      arId,
  output logic                 arReady,
  output logic                 rValid,
  output portalPkg::busData    rData,
  output portalPkg::txnId      rId,
  input  logic                 rReady,
  input  logic                 awValid,
  input  portalPkg::portalAddr awAddr,
  input  portalPkg::txnId      awId,
  output logic                 awReady,
  input  logic                 wValid,
  input  portalPkg::busData    wData,
  output logic                 wReady,
  output logic                 bValid,
  output portalPkg::txnId      bId,
  input  logic                 bReady,
  output logic                 irq
);

  portalPkg::portalOffset ctrlRdOffset;
  logic                   ctrlRdIndPortal;
  portalPkg::busData      ctrlRdData;
  logic                   intEnWrite;
  logic                   intEnValue;
  logic                   reqPush;
  portalPkg::busData      reqData;
  logic                   reqNotFull;
  logic                   indPop;
  logic                   indNotEmpty;
  portalPkg::busData      indData;

  readChannel readCh (
    .CLK(CLK), .RST_N(RST_N),
    .arValid(arValid), .arAddr(arAddr), .arId(arId), .arReady(arReady),
    .rValid(rValid), .rData(rData), .rId(rId), .rReady(rReady),
    .ctrlRdOffset(ctrlRdOffset), .ctrlRdIndPortal(ctrlRdIndPortal), .ctrlRdData(ctrlRdData),
    .indNotEmpty(indNotEmpty), .indPop(indPop), .indData(indData),
    .reqNotFull(reqNotFull)
  );

  writeChannel writeCh (
    .CLK(CLK), .RST_N(RST_N),
    .awValid(awValid), .awAddr(awAddr), .awId(awId), .awReady(awReady),
    .wValid(wValid), .wData(wData), .wReady(wReady),
    .bValid(bValid), .bId(bId), .bReady(bReady),
    .intEnWrite(intEnWrite), .intEnValue(intEnValue),
    .reqPush(reqPush), .reqData(reqData), .reqNotFull(reqNotFull)
  );

  portalCtrlRegs ctrlRegs (
    .CLK(CLK), .RST_N(RST_N),
    .ctrlRdOffset(ctrlRdOffset), .ctrlRdIndPortal(ctrlRdIndPortal), .ctrlRdData(ctrlRdData),
    .intEnWrite(intEnWrite), .intEnValue(intEnValue),
    .indNotEmpty(indNotEmpty), .irq(irq)
  );

  echoUser #(.queueDepth(queueDepth)) user (
    .CLK(CLK), .RST_N(RST_N),
    .reqPush(reqPush), .reqData(reqData), .reqNotFull(reqNotFull),
    .indPop(indPop), .indNotEmpty(indNotEmpty), .indData(indData)
  );

endmodule

`default_nettype wire

// ==== design/echoUser.sv ====
`timescale 1ns/1ns
`default_nettype none

module echoUser #(
  parameter int queueDepth = 4
) (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              reqPush,
  input  portalPkg::busData reqData,
  output logic              reqNotFull,
  input  logic              indPop,
  output logic              indNotEmpty,
  output portalPkg::busData indData
);

  localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntBits = $clog2(queueDepth + 1);

  portalPkg::busData  mem [queueDepth];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] count;
  logic               doPush;
  logic               doPop;

  assign reqNotFull  = (count != cntBits'(queueDepth));
  assign indNotEmpty = (count != '0);
  assign indData     = mem[rdPtr];  // Head word, echoed unchanged

  assign doPush = reqPush && reqNotFull;
  assign doPop  = indPop && indNotEmpty;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush)
        wrPtr <= (wrPtr == ptrBits'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == ptrBits'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush)
      mem[wrPtr] <= reqData;
  end

endmodule

`default_nettype wire

// ==== portalBridge/portalCtrlRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module portalCtrlRegs (
  input  logic                   CLK,
  input  logic                   RST_N,
  input  portalPkg::portalOffset ctrlRdOffset,
  input  logic                   ctrlRdIndPortal,
  output portalPkg::busData      ctrlRdData,
  input  logic                   intEnWrite,
  input  logic                   intEnValue,
  input  logic                   indNotEmpty,
  output logic                   irq
);

  logic intEnable;

  always_ff @(posedge CLK) begin
    if (!RST_N)
      intEnable <= 1'b0;
    else if (intEnWrite)
      intEnable <= intEnValue;
  end

  assign irq = intEnable && indNotEmpty;

  always_comb begin
    case (ctrlRdOffset)
      portalPkg::offIntStatus:
        ctrlRdData = {31'd0, ctrlRdIndPortal && indNotEmpty};  // Request side has no status
      portalPkg::offIntEnable:   ctrlRdData = {31'd0, intEnable};
      portalPkg::offNumTiles:    ctrlRdData = portalPkg::numTiles;
      portalPkg::offQueueStatus: ctrlRdData = {31'd0, indNotEmpty};
      portalPkg::offPortalId:
        ctrlRdData = ctrlRdIndPortal ? portalPkg::indPortalId : portalPkg::reqPortalId;
      portalPkg::offNumPortals:  ctrlRdData = portalPkg::numPortals;
      default:                   ctrlRdData = portalPkg::fillerWord;
    endcase
  end

endmodule

`default_nettype wire

// ==== portalBridge/writeChannel.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeChannel (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic                 awValid,
  input  portalPkg::portalAddr awAddr,
  input  portalPkg::txnId      awId,
  output logic                 awReady,
  input  logic                 wValid,
  input  portalPkg::busData    wData,
  output logic                 wReady,
  output logic                 bValid,
  output portalPkg::txnId      bId,
  input  logic                 bReady,
  output logic                 intEnWrite,
  output logic                 intEnValue,
  output logic                 reqPush,
  output portalPkg::busData    reqData,
  input  logic                 reqNotFull
);

  logic                 haveAddr;
  logic                 haveData;
  portalPkg::portalAddr addrReg;
  portalPkg::txnId      idReg;
  portalPkg::busData    dataReg;
  logic                 ctrlPage;
  logic                 pushTarget;
  logic                 enableTarget;
  logic                 act;

  // Each beat taken once per transaction
  assign awReady = !haveAddr;
  assign wReady  = !haveData;

  assign ctrlPage     = (addrReg[11:5] == 7'd0);
  assign pushTarget   = !ctrlPage && !addrReg[12] && (addrReg[4:0] == 5'h00);
  assign enableTarget = ctrlPage && (addrReg[4:0] == portalPkg::offIntEnable);

  // Fires once, when both beats are in and the target can take it
  assign act = haveAddr && haveData && !bValid && (!pushTarget || reqNotFull);

  assign reqPush    = act && pushTarget;
  assign reqData    = dataReg;
  assign intEnWrite = act && enableTarget;
  assign intEnValue = dataReg[0];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      haveAddr <= 1'b0;
      haveData <= 1'b0;
      bValid   <= 1'b0;
    end else begin
      if (awValid && awReady)
        haveAddr <= 1'b1;
      if (wValid && wReady)
        haveData <= 1'b1;
      if (act)
        bValid <= 1'b1;
      if (bValid && bReady) begin
        bValid   <= 1'b0;
        haveAddr <= 1'b0;
        haveData <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (awValid && awReady) begin
      addrReg <= awAddr;
      idReg   <= awId;
    end
    if (wValid && wReady)
      dataReg <= wData;
  end

  assign bId = idReg;

endmodule

`default_nettype wire

// ==== portalBridge/readChannel.sv ====
`timescale 1ns/1ns
`default_nettype none

module readChannel (
  input  logic                   CLK,
  input  logic                   RST_N,
  input  logic                   arValid,
  input  portalPkg::portalAddr   arAddr,
  input  portalPkg::txnId        arId,
  output logic                   arReady,
  output logic                   rValid,
  output portalPkg::busData      rData,
  output portalPkg::txnId        rId,
  input  logic                   rReady,
  output portalPkg::portalOffset ctrlRdOffset,
  output logic                   ctrlRdIndPortal,
  input  portalPkg::busData      ctrlRdData,
  input  logic                   indNotEmpty,
  output logic                   indPop,
  input  portalPkg::busData      indData,
  input  logic                   reqNotFull
);

  logic                 busy;     // One transaction at a time
  logic                 pending;  // Address held, response not built yet
  portalPkg::portalAddr addrReg;
  portalPkg::txnId      idReg;
  logic                 ctrlPage;
  logic                 popTarget;
  logic                 respond;
  portalPkg::busData    dataWord;

  assign arReady = !busy;

  // Decode of the held address
  assign ctrlPage        = (addrReg[11:5] == 7'd0);
  assign ctrlRdOffset    = addrReg[4:0];
  assign ctrlRdIndPortal = addrReg[12];
  assign popTarget       = !ctrlPage && addrReg[12] && (addrReg[4:0] == 5'h00);

  // Indication pop stalls until a word exists
  assign respond = pending && (!popTarget || indNotEmpty);
  assign indPop  = respond && popTarget;

  always_comb begin
    dataWord = '0;
    if (addrReg[4:0] == 5'h04)
      dataWord = {31'd0, addrReg[12] ? indNotEmpty : reqNotFull};  // Queue flags
    else if (popTarget)
      dataWord = indData;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      busy    <= 1'b0;
      pending <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      if (arValid && arReady) begin
        busy    <= 1'b1;
        pending <= 1'b1;
      end
      if (respond) begin
        pending <= 1'b0;
        rValid  <= 1'b1;
      end
      if (rValid && rReady) begin
        rValid <= 1'b0;
        busy   <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (arValid && arReady) begin
      addrReg <= arAddr;
      idReg   <= arId;
    end
    if (respond)
      rData <= ctrlPage ? ctrlRdData : dataWord;
  end

  assign rId = idReg;  // Held until the next accept

endmodule

`default_nettype wire

// ==== common/portalPkg.sv ====
`default_nettype none

package portalPkg;

  typedef logic [12:0] portalAddr;    // Host byte address
  typedef logic [4:0]  portalOffset;  // Word offset inside a page
  typedef logic [31:0] busData;
  typedef logic [5:0]  txnId;

  // Portal identity
  localparam busData reqPortalId = 32'd5;
  localparam busData indPortalId = 32'd6;
  localparam busData numTiles    = 32'd1;
  localparam busData numPortals  = 32'd2;

  // Unused control offsets read back this pattern
  localparam busData fillerWord  = 32'h005A05A0;

  // Control page map
  localparam portalOffset offIntStatus   = 5'h00;
  localparam portalOffset offIntEnable   = 5'h04;
  localparam portalOffset offNumTiles    = 5'h08;
  localparam portalOffset offQueueStatus = 5'h0C;
  localparam portalOffset offPortalId    = 5'h10;
  localparam portalOffset offNumPortals  = 5'h14;

endpackage

`default_nettype wire
